// File: rtl/shell_pkg.sv
// ----------------------------------------------------------
// Shell lite shared definitions
// Bus width, AXI response codes, register map and the
// identification word of the custom logic
// ----------------------------------------------------------

package shell_pkg;

   // Register and bus data width
   localparam int DATA_W = 32;

   // AXI response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // Register indices, byte address with low two bits dropped
   localparam int REG_ID  = 0;
   localparam int REG_CTL = 1;

   // Fixed identification word seen at REG_ID
   localparam logic [DATA_W-1:0] CL_ID = 32'h5E11_C0DE;

endpackage

// File: rtl/pcis_ctrl.sv
// ----------------------------------------------------------
// Host command controller
// Latches host commands, starts the AXI channel drivers,
// returns results and sequences function-level reset
// ----------------------------------------------------------

`timescale 1ns/1ns

module pcis_ctrl #(
   parameter int ADDR_W = 8
) (
   input  logic                         clk_out,
   input  logic                         rst_n_i,
   input  logic                         cmd_valid_i,
   input  logic                         cmd_write_i,
   input  logic [ADDR_W-1:0]            cmd_addr_i,
   input  logic [shell_pkg::DATA_W-1:0] cmd_wdata_i,
   input  logic                         flr_assert_i,
   input  logic                         wr_done_i,
   input  logic [1:0]                   wr_resp_i,
   input  logic                         rd_done_i,
   input  logic [shell_pkg::DATA_W-1:0] rd_data_i,
   input  logic [1:0]                   rd_resp_i,
   output logic                         cmd_busy_o,
   output logic                         cmd_done_o,
   output logic [shell_pkg::DATA_W-1:0] cmd_rdata_o,
   output logic [1:0]                   cmd_resp_o,
   output logic                         flr_done_o,
   output logic                         wr_start_o,
   output logic                         rd_start_o,
   output logic [ADDR_W-1:0]            addr_o,
   output logic [shell_pkg::DATA_W-1:0] wdata_o,
   output logic                         clr_o
);

   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_WRITE = 2'd1;
   localparam logic [1:0] ST_READ  = 2'd2;
   localparam logic [1:0] ST_CLR   = 2'd3;

   logic [1:0] state_q;
   logic       idle;

   assign idle       = (state_q == ST_IDLE);
   assign cmd_busy_o = !idle;

   // ----------------------------------------------------------
   // State machine and strobes
   // ----------------------------------------------------------
   always_ff @(posedge clk_out or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= ST_IDLE;
         wr_start_o <= 1'b0;
         rd_start_o <= 1'b0;
         cmd_done_o <= 1'b0;
         flr_done_o <= 1'b0;
         clr_o      <= 1'b0;
      end else begin
         wr_start_o <= 1'b0;
         rd_start_o <= 1'b0;
         cmd_done_o <= 1'b0;
         flr_done_o <= 1'b0;
         clr_o      <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               // FLR request wins over a command in the same cycle
               if (flr_assert_i) begin
                  state_q <= ST_CLR;
                  clr_o   <= 1'b1;
               end else if (cmd_valid_i) begin
                  state_q    <= cmd_write_i ? ST_WRITE : ST_READ;
                  wr_start_o <= cmd_write_i;
                  rd_start_o <= !cmd_write_i;
               end
            end
            ST_WRITE: begin
               if (wr_done_i) begin
                  state_q    <= ST_IDLE;
                  cmd_done_o <= 1'b1;
               end
            end
            ST_READ: begin
               if (rd_done_i) begin
                  state_q    <= ST_IDLE;
                  cmd_done_o <= 1'b1;
               end
            end
            default: begin
               // Slave clears on the clr edge, done follows
               state_q    <= ST_IDLE;
               flr_done_o <= 1'b1;
            end
         endcase
      end
   end

   // Command payload, held until the next acceptance
   always_ff @(posedge clk_out) begin
      if (idle && cmd_valid_i && !flr_assert_i) begin
         addr_o  <= cmd_addr_i;
         wdata_o <= cmd_wdata_i;
      end
   end

   // Results hold until the next completion
   always_ff @(posedge clk_out) begin
      if (state_q == ST_WRITE && wr_done_i) begin
         cmd_resp_o <= wr_resp_i;
      end else if (state_q == ST_READ && rd_done_i) begin
         cmd_resp_o  <= rd_resp_i;
         cmd_rdata_o <= rd_data_i;
      end
   end

   // Host must not strobe while a command or clear is running
   a_no_cmd_busy: assert property (@(posedge clk_out) disable iff (!rst_n_i)
      (cmd_valid_i || flr_assert_i) |-> !cmd_busy_o);

   // One start per busy window, only in its first cycle
   a_one_start: assert property (@(posedge clk_out) disable iff (!rst_n_i)
      (wr_start_o || rd_start_o) |-> (cmd_busy_o && !$past(cmd_busy_o)));

endmodule

// File: rtl/axi_wr_chan.sv
// ----------------------------------------------------------
// AXI write channel driver
// Single-beat write on aw and w, then waits for b
// ----------------------------------------------------------

`timescale 1ns/1ns

module axi_wr_chan #(
   parameter int ADDR_W = 8
) (
   input  logic                         clk_out,
   input  logic                         rst_n_i,
   input  logic                         start_i,
   input  logic [ADDR_W-1:0]            addr_i,
   input  logic [shell_pkg::DATA_W-1:0] wdata_i,
   input  logic                         awready_i,
   input  logic                         wready_i,
   input  logic                         bvalid_i,
   input  logic [1:0]                   bresp_i,
   output logic                         awvalid_o,
   output logic [ADDR_W-1:0]            awaddr_o,
   output logic                         wvalid_o,
   output logic [shell_pkg::DATA_W-1:0] wdata_o,
   output logic                         bready_o,
   output logic                         done_o,
   output logic [1:0]                   resp_o
);

   logic b_hs;

   assign b_hs = bvalid_i && bready_o;

   // Valids drop on their own handshakes, bready on the response
   always_ff @(posedge clk_out or negedge rst_n_i) begin
      if (!rst_n_i) begin
         awvalid_o <= 1'b0;
         wvalid_o  <= 1'b0;
         bready_o  <= 1'b0;
         done_o    <= 1'b0;
      end else begin
         awvalid_o <= start_i || (awvalid_o && !awready_i);
         wvalid_o  <= start_i || (wvalid_o && !wready_i);
         bready_o  <= start_i || (bready_o && !bvalid_i);
         done_o    <= b_hs;
      end
   end

   always_ff @(posedge clk_out) begin
      if (start_i) begin
         awaddr_o <= addr_i;
         wdata_o  <= wdata_i;
      end
      if (b_hs) begin
         resp_o <= bresp_i;
      end
   end

   a_awaddr_stable: assert property (@(posedge clk_out) disable iff (!rst_n_i)
      (awvalid_o && !awready_i) |=> $stable(awaddr_o));

endmodule

// File: rtl/axi_rd_chan.sv
// ----------------------------------------------------------
// AXI read channel driver
// Address goes out in the start cycle, data is captured
// on the r handshake
// ----------------------------------------------------------

`timescale 1ns/1ns

module axi_rd_chan #(
   parameter int ADDR_W = 8
) (
   input  logic                         clk_out,
   input  logic                         rst_n_i,
   input  logic                         start_i,
   input  logic [ADDR_W-1:0]            addr_i,
   input  logic                         arready_i,
   input  logic                         rvalid_i,
   input  logic [shell_pkg::DATA_W-1:0] rdata_i,
   input  logic [1:0]                   rresp_i,
   output logic                         arvalid_o,
   output logic [ADDR_W-1:0]            araddr_o,
   output logic                         rready_o,
   output logic                         done_o,
   output logic [shell_pkg::DATA_W-1:0] rdata_o,
   output logic [1:0]                   resp_o
);

   logic              ar_pend_q;
   logic [ADDR_W-1:0] addr_q;
   logic              r_hs;

   // Start cycle drives the input address, later cycles the held one
   assign arvalid_o = start_i || ar_pend_q;
   assign araddr_o  = ar_pend_q ? addr_q : addr_i;
   assign r_hs      = rvalid_i && rready_o;

   always_ff @(posedge clk_out or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ar_pend_q <= 1'b0;
         rready_o  <= 1'b0;
         done_o    <= 1'b0;
      end else begin
         ar_pend_q <= arvalid_o && !arready_i;
         rready_o  <= start_i || (rready_o && !rvalid_i);
         done_o    <= r_hs;
      end
   end

   always_ff @(posedge clk_out) begin
      if (start_i) begin
         addr_q <= addr_i;
      end
      if (r_hs) begin
         rdata_o <= rdata_i;
         resp_o  <= rresp_i;
      end
   end

   // Valid and address both hold until the slave takes them
   a_arvalid_hold: assert property (@(posedge clk_out) disable iff (!rst_n_i)
      (arvalid_o && !arready_i) |=> (arvalid_o && $stable(araddr_o)));

endmodule

// File: rtl/cl_reg_slave.sv
// ----------------------------------------------------------
// Custom logic register slave
// Single-beat AXI register file with an ID word, a control
// register and scratch registers, cleared by FLR
// ----------------------------------------------------------

`timescale 1ns/1ns

module cl_reg_slave #(
   parameter int ADDR_W   = 8,
   parameter int NUM_REGS = 8
) (
   input  logic                         clk_out,
   input  logic                         rst_n_i,
   input  logic                         clr_i,
   input  logic [ADDR_W-1:0]            awaddr_i,
   input  logic                         awvalid_i,
   output logic                         awready_o,
   input  logic [shell_pkg::DATA_W-1:0] wdata_i,
   input  logic                         wvalid_i,
   output logic                         wready_o,
   output logic [1:0]                   bresp_o,
   output logic                         bvalid_o,
   input  logic                         bready_i,
   input  logic [ADDR_W-1:0]            araddr_i,
   input  logic                         arvalid_i,
   output logic                         arready_o,
   output logic [shell_pkg::DATA_W-1:0] rdata_o,
   output logic [1:0]                   rresp_o,
   output logic                         rvalid_o,
   input  logic                         rready_i,
   output logic [shell_pkg::DATA_W-1:0] ctl_o
);

   // Storage for the writable registers only
   logic [shell_pkg::DATA_W-1:0] regs_q [1:NUM_REGS-1];
   logic [ADDR_W-3:0]            wr_idx, rd_idx;
   logic                         wr_hs, wr_ok, rd_hs;
   logic [shell_pkg::DATA_W-1:0] rd_data;
   logic [1:0]                   rd_resp;

   // Word index from the byte address
   assign wr_idx = awaddr_i[ADDR_W-1:2];
   assign rd_idx = araddr_i[ADDR_W-1:2];

   // Address and data accepted together and never over a pending response
   assign awready_o = awvalid_i && wvalid_i && !bvalid_o;
   assign wready_o  = awready_o;
   assign wr_hs     = awready_o;
   assign wr_ok     = (wr_idx != shell_pkg::REG_ID) && (wr_idx < NUM_REGS);

   assign arready_o = arvalid_i && !rvalid_o;
   assign rd_hs     = arready_o;

   assign ctl_o = regs_q[shell_pkg::REG_CTL];

   // ----------------------------------------------------------
   // Register file
   // ----------------------------------------------------------
   always_ff @(posedge clk_out or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 1; i < NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (clr_i) begin
         for (int i = 1; i < NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wr_hs && wr_ok) begin
         regs_q[wr_idx] <= wdata_i;
      end
   end

   // Read decode with the ID word at index 0
   always_comb begin
      rd_data = '0;
      rd_resp = shell_pkg::RESP_OKAY;
      if (rd_idx == shell_pkg::REG_ID) begin
         rd_data = shell_pkg::CL_ID;
      end else if (rd_idx < NUM_REGS) begin
         rd_data = regs_q[rd_idx];
      end else begin
         rd_resp = shell_pkg::RESP_SLVERR;
      end
   end

   // ----------------------------------------------------------
   // Response channels
   // ----------------------------------------------------------
   always_ff @(posedge clk_out or negedge rst_n_i) begin
      if (!rst_n_i) begin
         bvalid_o <= 1'b0;
         rvalid_o <= 1'b0;
      end else begin
         bvalid_o <= wr_hs || (bvalid_o && !bready_i);
         rvalid_o <= rd_hs || (rvalid_o && !rready_i);
      end
   end

   always_ff @(posedge clk_out) begin
      if (wr_hs) begin
         bresp_o <= wr_ok ? shell_pkg::RESP_OKAY : shell_pkg::RESP_SLVERR;
      end
      if (rd_hs) begin
         rdata_o <= rd_data;
         rresp_o <= rd_resp;
      end
   end

   // Response stays valid and unchanged until the driver takes it
   a_bvalid_hold: assert property (@(posedge clk_out) disable iff (!rst_n_i)
      (bvalid_o && !bready_i) |=> (bvalid_o && $stable(bresp_o)));

endmodule

// File: rtl/shell_lite_top.sv
// ----------------------------------------------------------
// Shell lite top level
// Host command port, AXI write and read channel drivers and
// the custom logic register slave behind them
// ----------------------------------------------------------

`timescale 1ns/1ns

module shell_lite_top #(
   parameter int ADDR_W   = 8,
   parameter int NUM_REGS = 8
) (
   input  logic                        clk_out,
   input  logic                        rst_n_i,
   input  logic                        cmd_valid_i,
   input  logic                        cmd_write_i,
   input  logic [ADDR_W-1:0]           cmd_addr_i,
   input  logic [shell_pkg::DATA_W-1:0] cmd_wdata_i,
   input  logic                        flr_assert_i,
   output logic                        cmd_busy_o,
   output logic                        cmd_done_o,
   output logic [shell_pkg::DATA_W-1:0] cmd_rdata_o,
   output logic [1:0]                  cmd_resp_o,
   output logic                        flr_done_o,
   output logic [shell_pkg::DATA_W-1:0] ctl_o
);

   // Controller to drivers
   logic                         wr_start, rd_start, wr_done, rd_done, clr;
   logic [ADDR_W-1:0]            addr;
   logic [shell_pkg::DATA_W-1:0] wdata, rd_data;
   logic [1:0]                   wr_resp, rd_resp;

   // AXI channels
   logic                         awvalid, awready, wvalid, wready, bvalid, bready;
   logic                         arvalid, arready, rvalid, rready;
   logic [ADDR_W-1:0]            awaddr, araddr;
   logic [shell_pkg::DATA_W-1:0] axi_wdata, axi_rdata;
   logic [1:0]                   bresp, rresp;

   pcis_ctrl #(.ADDR_W(ADDR_W)) ctrl_i (
      .clk_out      (clk_out),
      .rst_n_i      (rst_n_i),
      .cmd_valid_i  (cmd_valid_i),
      .cmd_write_i  (cmd_write_i),
      .cmd_addr_i   (cmd_addr_i),
      .cmd_wdata_i  (cmd_wdata_i),
      .flr_assert_i (flr_assert_i),
      .wr_done_i    (wr_done),
      .wr_resp_i    (wr_resp),
      .rd_done_i    (rd_done),
      .rd_data_i    (rd_data),
      .rd_resp_i    (rd_resp),
      .cmd_busy_o   (cmd_busy_o),
      .cmd_done_o   (cmd_done_o),
      .cmd_rdata_o  (cmd_rdata_o),
      .cmd_resp_o   (cmd_resp_o),
      .flr_done_o   (flr_done_o),
      .wr_start_o   (wr_start),
      .rd_start_o   (rd_start),
      .addr_o       (addr),
      .wdata_o      (wdata),
      .clr_o        (clr)
   );

   axi_wr_chan #(.ADDR_W(ADDR_W)) wr_chan_i (
      .clk_out   (clk_out),
      .rst_n_i   (rst_n_i),
      .start_i   (wr_start),
      .addr_i    (addr),
      .wdata_i   (wdata),
      .awready_i (awready),
      .wready_i  (wready),
      .bvalid_i  (bvalid),
      .bresp_i   (bresp),
      .awvalid_o (awvalid),
      .awaddr_o  (awaddr),
      .wvalid_o  (wvalid),
      .wdata_o   (axi_wdata),
      .bready_o  (bready),
      .done_o    (wr_done),
      .resp_o    (wr_resp)
   );

   axi_rd_chan #(.ADDR_W(ADDR_W)) rd_chan_i (
      .clk_out   (clk_out),
      .rst_n_i   (rst_n_i),
      .start_i   (rd_start),
      .addr_i    (addr),
      .arready_i (arready),
      .rvalid_i  (rvalid),
      .rdata_i   (axi_rdata),
      .rresp_i   (rresp),
      .arvalid_o (arvalid),
      .araddr_o  (araddr),
      .rready_o  (rready),
      .done_o    (rd_done),
      .rdata_o   (rd_data),
      .resp_o    (rd_resp)
   );

   cl_reg_slave #(.ADDR_W(ADDR_W), .NUM_REGS(NUM_REGS)) slave_i (
      .clk_out   (clk_out),
      .rst_n_i   (rst_n_i),
      .clr_i     (clr),
      .awaddr_i  (awaddr),
      .awvalid_i (awvalid),
      .awready_o (awready),
      .wdata_i   (axi_wdata),
      .wvalid_i  (wvalid),
      .wready_o  (wready),
      .bresp_o   (bresp),
      .bvalid_o  (bvalid),
      .bready_i  (bready),
      .araddr_i  (araddr),
      .arvalid_i (arvalid),
      .arready_o (arready),
      .rdata_o   (axi_rdata),
      .rresp_o   (rresp),
      .rvalid_o  (rvalid),
      .rready_i  (rready),
      .ctl_o     (ctl_o)
   );

endmodule

// File: tests/tb_shell_lite.sv
// ----------------------------------------------------------
// Shell lite testbench
// Directed tests of host register writes and reads through
// the AXI bridge, error responses and function-level reset
// ----------------------------------------------------------

`timescale 1ns/1ns

module tb_shell_lite;

   localparam int ADDR_W      = 8;
   localparam int NUM_REGS    = 8;
   localparam int CLK_NS      = 4;
   localparam int DONE_WAIT   = 20;
   localparam int NUM_TESTS   = 6;
   localparam int WATCHDOG_NS = NUM_TESTS * 400 * CLK_NS;

   logic                         clk_out;
   logic                         rst_n_i;
   logic                         cmd_valid_i;
   logic                         cmd_write_i;
   logic [ADDR_W-1:0]            cmd_addr_i;
   logic [shell_pkg::DATA_W-1:0] cmd_wdata_i;
   logic                         flr_assert_i;
   logic                         cmd_busy_o;
   logic                         cmd_done_o;
   logic [shell_pkg::DATA_W-1:0] cmd_rdata_o;
   logic [1:0]                   cmd_resp_o;
   logic                         flr_done_o;
   logic [shell_pkg::DATA_W-1:0] ctl_o;

   // Expected register contents
   logic [31:0] model [NUM_REGS];
   logic [31:0] rnd_state;
   int          errors;
   int          tests_passed;
   int          tests_failed;

   shell_lite_top #(.ADDR_W(ADDR_W), .NUM_REGS(NUM_REGS)) dut_i (
      .clk_out      (clk_out),
      .rst_n_i      (rst_n_i),
      .cmd_valid_i  (cmd_valid_i),
      .cmd_write_i  (cmd_write_i),
      .cmd_addr_i   (cmd_addr_i),
      .cmd_wdata_i  (cmd_wdata_i),
      .flr_assert_i (flr_assert_i),
      .cmd_busy_o   (cmd_busy_o),
      .cmd_done_o   (cmd_done_o),
      .cmd_rdata_o  (cmd_rdata_o),
      .cmd_resp_o   (cmd_resp_o),
      .flr_done_o   (flr_done_o),
      .ctl_o        (ctl_o)
   );

   initial begin
      clk_out = 1'b0;
      forever #(CLK_NS / 2) clk_out = ~clk_out;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
      $display("** FAIL **");
      $finish;
   end

   // ----------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      rnd_state = xorshift(rnd_state);
      return rnd_state;
   endfunction

   function automatic logic [ADDR_W-1:0] byte_addr(input int idx);
      return ADDR_W'(idx * 4);
   endfunction

   // Inputs change 1 ns after the rising edge, outputs are read there too
   task automatic next_cycle();
      @(posedge clk_out);
      #1;
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("Fail t=%0t %s expected %0h got %0h", $time, name, exp, act);
      errors++;
   endtask

   // Busy must stay high from acceptance up to the done pulse
   task automatic wait_cmd_done();
      int n;
      n = 0;
      while (!cmd_done_o && n < DONE_WAIT) begin
         if (cmd_busy_o !== 1'b1) begin
            report_mismatch("cmd_busy_o", 1, cmd_busy_o);
         end
         next_cycle();
         n++;
      end
      if (!cmd_done_o) begin
         $display("Error at %0t: no cmd_done_o within %0d cycles", $time, DONE_WAIT);
         errors++;
      end
   endtask

   task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
      cmd_valid_i = 1'b1;
      cmd_write_i = 1'b1;
      cmd_addr_i  = addr;
      cmd_wdata_i = data;
      next_cycle();
      cmd_valid_i = 1'b0;
      wait_cmd_done();
      resp = cmd_resp_o;
   endtask

   task automatic host_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
      cmd_valid_i = 1'b1;
      cmd_write_i = 1'b0;
      cmd_addr_i  = addr;
      next_cycle();
      cmd_valid_i = 1'b0;
      wait_cmd_done();
      data = cmd_rdata_o;
      resp = cmd_resp_o;
   endtask

   task automatic write_and_compare(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                                    input logic [1:0] exp_resp);
      logic [1:0] resp;
      host_write(addr, data, resp);
      if (resp !== exp_resp) begin
         report_mismatch("cmd_resp_o", exp_resp, resp);
      end
   endtask

   task automatic read_and_compare(input logic [ADDR_W-1:0] addr, input logic [31:0] exp_data,
                                   input logic [1:0] exp_resp);
      logic [31:0] data;
      logic [1:0]  resp;
      host_read(addr, data, resp);
      if (data !== exp_data) begin
         report_mismatch("cmd_rdata_o", exp_data, data);
      end
      if (resp !== exp_resp) begin
         report_mismatch("cmd_resp_o", exp_resp, resp);
      end
   endtask

   // Reads every writable register against the model, then ctl_o
   task automatic compare_writable();
      for (int i = 1; i < NUM_REGS; i++) begin
         read_and_compare(byte_addr(i), model[i], shell_pkg::RESP_OKAY);
      end
      if (ctl_o !== model[shell_pkg::REG_CTL]) begin
         report_mismatch("ctl_o", model[shell_pkg::REG_CTL], ctl_o);
      end
   endtask

   task automatic end_test(input string name, input int errs_at_start);
      if (errors == errs_at_start) begin
         tests_passed++;
         $display("Test %s finished, no errors", name);
      end else begin
         tests_failed++;
         $display("Test %s finished, %0d errors", name, errors - errs_at_start);
      end
   endtask

   // ----------------------------------------------------------
   // Tests
   // ----------------------------------------------------------
   task automatic read_after_reset();
      int errs0;
      errs0 = errors;
      read_and_compare(byte_addr(shell_pkg::REG_ID), shell_pkg::CL_ID, shell_pkg::RESP_OKAY);
      compare_writable();
      end_test("read_after_reset", errs0);
   endtask

   task automatic write_readback();
      int errs0;
      errs0 = errors;
      for (int i = 1; i < NUM_REGS; i++) begin
         model[i] = next_random();
         write_and_compare(byte_addr(i), model[i], shell_pkg::RESP_OKAY);
      end
      // Second control write, ctl_o follows the latest one
      model[shell_pkg::REG_CTL] = next_random();
      write_and_compare(byte_addr(shell_pkg::REG_CTL), model[shell_pkg::REG_CTL],
                        shell_pkg::RESP_OKAY);
      compare_writable();
      end_test("write_readback", errs0);
   endtask

   task automatic id_write_rejected();
      int errs0;
      errs0 = errors;
      write_and_compare(byte_addr(shell_pkg::REG_ID), 32'hFFFF_FFFF, shell_pkg::RESP_SLVERR);
      read_and_compare(byte_addr(shell_pkg::REG_ID), shell_pkg::CL_ID, shell_pkg::RESP_OKAY);
      end_test("id_write_rejected", errs0);
   endtask

   task automatic out_of_range_access();
      int errs0;
      errs0 = errors;
      write_and_compare(byte_addr(NUM_REGS), 32'hDEAD_BEEF, shell_pkg::RESP_SLVERR);
      read_and_compare(byte_addr(NUM_REGS), 32'h0, shell_pkg::RESP_SLVERR);
      // Highest word of the address space
      write_and_compare(8'hFC, 32'h1234_5678, shell_pkg::RESP_SLVERR);
      read_and_compare(8'hFC, 32'h0, shell_pkg::RESP_SLVERR);
      compare_writable();
      end_test("out_of_range_access", errs0);
   endtask

   task automatic flr_clear();
      int errs0;
      errs0 = errors;
      flr_assert_i = 1'b1;
      next_cycle();
      flr_assert_i = 1'b0;
      if (flr_done_o !== 1'b0) begin
         report_mismatch("flr_done_o", 0, flr_done_o);
      end
      next_cycle();
      if (flr_done_o !== 1'b1) begin
         report_mismatch("flr_done_o", 1, flr_done_o);
      end
      for (int i = 1; i < NUM_REGS; i++) begin
         model[i] = 32'h0;
      end
      compare_writable();
      read_and_compare(byte_addr(shell_pkg::REG_ID), shell_pkg::CL_ID, shell_pkg::RESP_OKAY);
      end_test("flr_clear", errs0);
   endtask

   task automatic random_access();
      int          errs0;
      int          idx;
      logic [31:0] data;
      errs0 = errors;
      repeat (20) begin
         idx       = 1 + int'(next_random() % 32'(NUM_REGS - 1));
         data      = next_random();
         model[idx] = data;
         write_and_compare(byte_addr(idx), data, shell_pkg::RESP_OKAY);
      end
      compare_writable();
      end_test("random_access", errs0);
   endtask

   initial begin
      rst_n_i      = 1'b0;
      cmd_valid_i  = 1'b0;
      cmd_write_i  = 1'b0;
      cmd_addr_i   = '0;
      cmd_wdata_i  = '0;
      flr_assert_i = 1'b0;
      rnd_state    = 32'd7;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      for (int i = 0; i < NUM_REGS; i++) begin
         model[i] = 32'h0;
      end
      repeat (5) @(posedge clk_out);
      #1;
      rst_n_i = 1'b1;

      read_after_reset();
      write_readback();
      id_write_rejected();
      out_of_range_access();
      flr_clear();
      random_access();

      $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: shell_lite.f
rtl/shell_pkg.sv
rtl/pcis_ctrl.sv
rtl/axi_wr_chan.sv
rtl/axi_rd_chan.sv
rtl/cl_reg_slave.sv
rtl/shell_lite_top.sv
tests/tb_shell_lite.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the shell lite testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -sv \
   -f shell_lite.f --top-module tb_shell_lite -o tb_shell_lite \
   && { out="$(./obj_dir/tb_shell_lite)"; printf '%s\n' "$out"; } \
   && printf '%s\n' "$out" | grep -qF '** PASS **' \
   && echo "run_sim: simulation passed" \
   || { echo "run_sim: simulation failed"; exit 1; }
